//--- logic/eth_pkg.sv
`default_nettype none

package eth_pkg;

    // Frame delimiting bytes
    localparam logic [7:0] preamble_byte = 8'h55;
    localparam logic [7:0] sfd_byte      = 8'hD5;   // Start of frame delimiter

    // Preamble bytes ahead of the SFD
    localparam int preamble_len = 7;

    // Minimum frame length ahead of the FCS, short frames padded up to this
    localparam int min_payload = 60;

    // Reflected CRC-32 register seed
    localparam logic [31:0] crc_init = 32'hFFFF_FFFF;

    // Register value left once a good frame and its own FCS have gone through
    localparam logic [31:0] crc_residue = 32'hDEBB_20E3;

    // Link speed codes
    localparam logic [1:0] link_1000 = 2'b10;
    localparam logic [1:0] link_100  = 2'b01;
    localparam logic [1:0] link_10   = 2'b00;

    // Receive deframer states
    typedef enum logic [1:0] {
        rx_idle,        // Waiting for rx_dv
        rx_preamble,    // Inside preamble, looking for SFD
        rx_data,        // Frame body, FCS included
        rx_drop         // Bad preamble, wait for rx_dv to drop
    } rx_state_t;

endpackage : eth_pkg

`default_nettype wire

//--- logic/crc32_engine.sv
`default_nettype none

// Byte-serial Ethernet CRC-32, reflected form, LSB of each byte first
module crc32_engine
    import eth_pkg::*;
(
    input  logic        clk_125,
    input  logic        reset,
    input  logic        clear,      // Reload seed, wins over enable
    input  logic        enable,     // Absorb data this cycle
    input  logic [7:0]  data,
    output logic [31:0] crc
);

    localparam logic [31:0] crc_poly = 32'hEDB8_8320;  // Reversed 04C11DB7

    logic [31:0] crc_next;

    // One shift per bit, data LSB enters first
    always_comb begin
        crc_next = crc;
        for (int i = 0; i < 8; i++) begin
            if (crc_next[0] ^ data[i]) begin
                crc_next = (crc_next >> 1) ^ crc_poly;
            end else begin
                crc_next = crc_next >> 1;
            end
        end
    end

    always_ff @(posedge clk_125) begin
        if (reset || clear) begin
            crc <= crc_init;
        end else if (enable) begin
            crc <= crc_next;
        end
    end

endmodule : crc32_engine

`default_nettype wire

//--- logic/tx_mac.sv
`default_nettype none

// Transmit framer: preamble, SFD, payload, zero pad, FCS, then inter-frame gap
module tx_mac
    import eth_pkg::*;
#(
    parameter int IFG_SIZE = 12
) (
    input  logic       clk_125,
    input  logic       reset,

    // Byte stream from the transmit FIFO
    input  logic [7:0] s_tx_axis_tdata,
    input  logic       s_tx_axis_tvalid,
    input  logic       s_tx_axis_tlast,
    output logic       s_tx_axis_trdy,

    // GMII transmit side
    output logic [7:0] gmii_tx_d,
    output logic       gmii_tx_en,
    output logic       gmii_tx_er
);

    // Counter must reach both the gap length and the minimum frame length
    localparam int cnt_max = (IFG_SIZE > min_payload) ? IFG_SIZE : min_payload;
    localparam int cnt_w   = $clog2(cnt_max + 1);

    localparam logic [2:0] st_idle     = 3'd0;
    localparam logic [2:0] st_preamble = 3'd1;
    localparam logic [2:0] st_payload  = 3'd2;
    localparam logic [2:0] st_pad      = 3'd3;
    localparam logic [2:0] st_fcs      = 3'd4;
    localparam logic [2:0] st_gap      = 3'd5;

    logic [2:0]       state;
    logic [cnt_w-1:0] byte_cnt;    // Preamble index, frame length, FCS index or gap length
    logic [23:0]      fcs_sr;      // Upper three FCS bytes, shifted out LSB first
    logic             crc_clear;
    logic             crc_enable;
    logic [7:0]       crc_data;
    logic [31:0]      crc;

    // FIFO read strobe, payload phase only
    assign s_tx_axis_trdy = (state == st_payload);

    // CRC covers payload and padding
    assign crc_clear  = (state == st_idle);
    assign crc_enable = ((state == st_payload) && s_tx_axis_tvalid) || (state == st_pad);
    assign crc_data   = (state == st_pad) ? 8'h00 : s_tx_axis_tdata;

    crc32_engine i_crc32_engine (
        .clk_125 (clk_125),
        .reset   (reset),
        .clear   (crc_clear),
        .enable  (crc_enable),
        .data    (crc_data),
        .crc     (crc)
    );

    always_ff @(posedge clk_125) begin
        if (reset) begin
            state      <= st_idle;
            byte_cnt   <= '0;
            gmii_tx_en <= 1'b0;
            gmii_tx_er <= 1'b0;
        end else begin
            gmii_tx_er <= 1'b0;    // Error strobe lasts a single cycle

            case (state)
                st_idle: begin
                    gmii_tx_d <= 8'h00;
                    if (s_tx_axis_tvalid) begin
                        // First preamble byte goes out right away
                        state      <= st_preamble;
                        byte_cnt   <= '0;
                        gmii_tx_en <= 1'b1;
                        gmii_tx_d  <= preamble_byte;
                    end
                end

                st_preamble: begin
                    byte_cnt <= byte_cnt + 1'b1;
                    if (byte_cnt == cnt_w'(preamble_len - 1)) begin
                        gmii_tx_d <= sfd_byte;    // After the seventh preamble byte
                        state     <= st_payload;
                        byte_cnt  <= '0;
                    end else begin
                        gmii_tx_d <= preamble_byte;
                    end
                end

                st_payload: begin
                    if (s_tx_axis_tvalid) begin
                        gmii_tx_d <= s_tx_axis_tdata;
                        if (byte_cnt < cnt_w'(min_payload)) begin
                            byte_cnt <= byte_cnt + 1'b1;    // Saturates once the minimum is met
                        end
                        if (s_tx_axis_tlast) begin
                            if (byte_cnt < cnt_w'(min_payload - 1)) begin
                                state <= st_pad;
                            end else begin
                                state    <= st_fcs;
                                byte_cnt <= '0;
                            end
                        end
                    end else begin
                        // Underflow, abort without FCS
                        gmii_tx_d  <= 8'h00;
                        gmii_tx_er <= 1'b1;
                        state      <= st_gap;
                        byte_cnt   <= '0;
                    end
                end

                st_pad: begin
                    gmii_tx_d <= 8'h00;
                    byte_cnt  <= byte_cnt + 1'b1;
                    if (byte_cnt == cnt_w'(min_payload - 1)) begin
                        state    <= st_fcs;
                        byte_cnt <= '0;
                    end
                end

                st_fcs: begin
                    byte_cnt <= byte_cnt + 1'b1;
                    if (byte_cnt == '0) begin
                        // CRC is final here, send it inverted
                        gmii_tx_d <= ~crc[7:0];
                        fcs_sr    <= ~crc[31:8];
                    end else begin
                        gmii_tx_d <= fcs_sr[7:0];
                        fcs_sr    <= {8'h00, fcs_sr[23:8]};
                    end
                    if (byte_cnt == cnt_w'(3)) begin
                        state    <= st_gap;
                        byte_cnt <= '0;
                    end
                end

                st_gap: begin
                    gmii_tx_en <= 1'b0;
                    gmii_tx_d  <= 8'h00;
                    byte_cnt   <= byte_cnt + 1'b1;
                    if (byte_cnt == cnt_w'(IFG_SIZE - 1)) begin
                        state    <= st_idle;
                        byte_cnt <= '0;
                    end
                end

                default: begin
                    state      <= st_idle;
                    gmii_tx_en <= 1'b0;
                end
            endcase
        end
    end

endmodule : tx_mac

`default_nettype wire

//--- logic/rx_mac.sv
`default_nettype none

// Receive deframer: strips preamble and FCS, flags CRC, PHY and overflow errors
module rx_mac
    import eth_pkg::*;
(
    input  logic       clk_125,
    input  logic       reset,

    // GMII receive side
    input  logic [7:0] gmii_rx_d,
    input  logic       gmii_rx_dv,
    input  logic       gmii_rx_er,

    // Byte stream toward the receive FIFO, cannot be stalled
    output logic [7:0] m_rx_axis_tdata,
    output logic       m_rx_axis_tvalid,
    output logic       m_rx_axis_tlast,
    output logic       m_rx_axis_tuser,
    input  logic       s_rx_axis_trdy
);

    logic [7:0]      rx_d_q;        // Registered GMII inputs
    logic            rx_dv_q;
    logic            rx_er_q;
    rx_state_t       state;
    logic [3:0][7:0] dly;           // FCS delay line, dly[3] oldest
    logic [2:0]      fill;          // Bytes held in the delay line, up to 4
    logic            er_flag;       // Sticky rx_er seen in this frame
    logic            ovf_flag;      // Sticky byte lost to the sink
    logic            sfd_hit;
    logic            crc_enable;
    logic [31:0]     crc;

    assign sfd_hit    = (state == rx_preamble) && rx_dv_q && (rx_d_q == sfd_byte);
    assign crc_enable = (state == rx_data) && rx_dv_q;    // FCS goes through as well

    crc32_engine i_crc32_engine (
        .clk_125 (clk_125),
        .reset   (reset),
        .clear   (sfd_hit),
        .enable  (crc_enable),
        .data    (rx_d_q),
        .crc     (crc)
    );

    // CRC already holds the FCS when tlast is up
    assign m_rx_axis_tuser = m_rx_axis_tlast && ((crc != crc_residue) || er_flag || ovf_flag);

    always_ff @(posedge clk_125) begin
        rx_d_q <= gmii_rx_d;
        if (reset) begin
            rx_dv_q <= 1'b0;
            rx_er_q <= 1'b0;
        end else begin
            rx_dv_q <= gmii_rx_dv;
            rx_er_q <= gmii_rx_er;
        end
    end

    always_ff @(posedge clk_125) begin
        if (reset) begin
            state            <= rx_idle;
            fill             <= '0;
            er_flag          <= 1'b0;
            ovf_flag         <= 1'b0;
            m_rx_axis_tvalid <= 1'b0;
            m_rx_axis_tlast  <= 1'b0;
        end else begin
            m_rx_axis_tvalid <= 1'b0;
            m_rx_axis_tlast  <= 1'b0;

            // Byte offered while the sink was not ready is gone
            if (m_rx_axis_tvalid && !s_rx_axis_trdy) begin
                ovf_flag <= 1'b1;
            end

            case (state)
                rx_idle: begin
                    if (rx_dv_q) begin
                        state <= (rx_d_q == preamble_byte) ? rx_preamble : rx_drop;
                    end
                end

                rx_preamble: begin
                    if (!rx_dv_q) begin
                        state <= rx_idle;
                    end else if (rx_d_q == sfd_byte) begin
                        state    <= rx_data;
                        fill     <= '0;
                        er_flag  <= 1'b0;    // New frame, fresh error state
                        ovf_flag <= 1'b0;
                    end else if (rx_d_q != preamble_byte) begin
                        state <= rx_drop;
                    end
                end

                rx_data: begin
                    if (!rx_dv_q) begin
                        state <= rx_idle;    // tlast already issued a cycle earlier
                    end else begin
                        dly <= {dly[2:0], rx_d_q};
                        if (rx_er_q) begin
                            er_flag <= 1'b1;
                        end
                        if (fill == 3'd4) begin
                            m_rx_axis_tvalid <= 1'b1;
                            m_rx_axis_tdata  <= dly[3];
                            m_rx_axis_tlast  <= !gmii_rx_dv;    // Line now holds only the FCS
                        end else begin
                            fill <= fill + 1'b1;
                        end
                    end
                end

                rx_drop: begin
                    if (!rx_dv_q) begin
                        state <= rx_idle;
                    end
                end

                default: state <= rx_idle;
            endcase
        end
    end

endmodule : rx_mac

`default_nettype wire

//--- logic/link_speed_detect.sv
`default_nettype none

// Measures one period of phy_rxc / 8 in clk_125 cycles
module link_speed_detect
    import eth_pkg::*;
#(
    parameter int SPEED_100_THRESHOLD = 16
) (
    input  logic       clk_125,
    input  logic       reset,
    input  logic       phy_rxc,
    output logic [1:0] link_speed
);

    logic [2:0] div_cnt;     // Runs on phy_rxc, MSB is the clock divided by 8
    logic [2:0] rxc_rt;      // Retiming stages in clk_125
    logic       rxc_edge;
    logic [1:0] edge_cnt;    // Edges seen in the current period
    logic [6:0] ref_cnt;     // clk_125 cycles since the period began

    always_ff @(posedge phy_rxc) begin
        if (reset) begin
            div_cnt <= '0;
        end else begin
            div_cnt <= div_cnt + 1'b1;
        end
    end

    assign rxc_edge = rxc_rt[2] ^ rxc_rt[1];    // Either edge of the divided clock

    always_ff @(posedge clk_125) begin
        if (reset) begin
            rxc_rt     <= '0;
            edge_cnt   <= '0;
            ref_cnt    <= '0;
            link_speed <= link_1000;
        end else begin
            rxc_rt  <= {rxc_rt[1:0], div_cnt[2]};
            ref_cnt <= ref_cnt + 1'b1;

            if (rxc_edge) begin
                if (edge_cnt == 2'd2) begin
                    // Third edge closes the period and opens the next one
                    edge_cnt   <= 2'd1;
                    ref_cnt    <= '0;
                    link_speed <= (ref_cnt >= SPEED_100_THRESHOLD) ? link_100 : link_1000;
                end else begin
                    if (edge_cnt == 2'd0) begin
                        ref_cnt <= '0;    // Period starts here
                    end
                    edge_cnt <= edge_cnt + 1'b1;
                end
            end else if (&ref_cnt) begin
                // No full period within 128 cycles, slowest link
                edge_cnt   <= '0;
                link_speed <= link_10;
            end
        end
    end

endmodule : link_speed_detect

`default_nettype wire

//--- logic/ethernet_mac.sv
`default_nettype none

// MAC subsystem top, GMII-style byte bus on clk_125
module ethernet_mac #(
    parameter int IFG_SIZE            = 12,    // Idle cycles between frames
    parameter int SPEED_100_THRESHOLD = 16     // Reference count for 100 Mb/s
) (
    input  logic       clk_125,
    input  logic       reset,

    // PHY side
    input  logic       phy_rxc,
    input  logic [7:0] gmii_rx_d,
    input  logic       gmii_rx_dv,
    input  logic       gmii_rx_er,
    output logic [7:0] gmii_tx_d,
    output logic       gmii_tx_en,
    output logic       gmii_tx_er,

    // Transmit stream
    input  logic [7:0] s_tx_axis_tdata,
    input  logic       s_tx_axis_tvalid,
    input  logic       s_tx_axis_tlast,
    output logic       s_tx_axis_trdy,

    // Receive stream
    output logic [7:0] m_rx_axis_tdata,
    output logic       m_rx_axis_tvalid,
    output logic       m_rx_axis_tlast,
    output logic       m_rx_axis_tuser,
    input  logic       s_rx_axis_trdy,

    output logic [1:0] link_speed     // Reported only
);

    tx_mac #(
        .IFG_SIZE (IFG_SIZE)
    ) i_tx_mac (
        .clk_125          (clk_125),
        .reset            (reset),
        .s_tx_axis_tdata  (s_tx_axis_tdata),
        .s_tx_axis_tvalid (s_tx_axis_tvalid),
        .s_tx_axis_tlast  (s_tx_axis_tlast),
        .s_tx_axis_trdy   (s_tx_axis_trdy),
        .gmii_tx_d        (gmii_tx_d),
        .gmii_tx_en       (gmii_tx_en),
        .gmii_tx_er       (gmii_tx_er)
    );

    rx_mac i_rx_mac (
        .clk_125          (clk_125),
        .reset            (reset),
        .gmii_rx_d        (gmii_rx_d),
        .gmii_rx_dv       (gmii_rx_dv),
        .gmii_rx_er       (gmii_rx_er),
        .m_rx_axis_tdata  (m_rx_axis_tdata),
        .m_rx_axis_tvalid (m_rx_axis_tvalid),
        .m_rx_axis_tlast  (m_rx_axis_tlast),
        .m_rx_axis_tuser  (m_rx_axis_tuser),
        .s_rx_axis_trdy   (s_rx_axis_trdy)
    );

    link_speed_detect #(
        .SPEED_100_THRESHOLD (SPEED_100_THRESHOLD)
    ) i_link_speed_detect (
        .clk_125    (clk_125),
        .reset      (reset),
        .phy_rxc    (phy_rxc),
        .link_speed (link_speed)
    );

endmodule : ethernet_mac

`default_nettype wire

//--- testbench/eth_frame_model.svh
`ifndef ETH_FRAME_MODEL_SVH
`define ETH_FRAME_MODEL_SVH
`default_nettype none

// Byte queue used for payloads and wire frames
typedef logic [7:0] byte_q_t[$];

logic [31:0] lfsr_state = 32'haccfee50;    // Generator state, fixed seed

// One Galois step, the bit shifted out is the random bit
function automatic logic lfsr_bit();
    logic out_bit;
    out_bit    = lfsr_state[0];
    lfsr_state = lfsr_state >> 1;
    if (out_bit) begin
        lfsr_state = lfsr_state ^ 32'h8020_0003;    // Feedback mask
    end
    return out_bit;
endfunction

// n random bits, one generator step per bit
function automatic logic [31:0] random_bits(input int n);
    logic [31:0] value;
    value = '0;
    for (int i = 0; i < n; i++) begin
        value = {value[30:0], lfsr_bit()};
    end
    return value;
endfunction

// Reflected CRC-32, whole byte folded in first, then eight shifts
function automatic logic [31:0] crc_byte(input logic [31:0] crc, input logic [7:0] data);
    logic [31:0] c;
    c = crc ^ {24'h0, data};
    for (int k = 0; k < 8; k++) begin
        c = c[0] ? ((c >> 1) ^ 32'hEDB8_8320) : (c >> 1);
    end
    return c;
endfunction

// Zero pad up to the minimum length
function automatic void pad_payload(input byte_q_t payload, output byte_q_t padded);
    padded = payload;
    while (padded.size() < min_payload) begin
        padded.push_back(8'h00);
    end
endfunction

// Preamble, SFD, padded payload, then inverted CRC with LSB byte first
function automatic void build_wire_frame(input byte_q_t padded, output byte_q_t wire_bytes);
    logic [31:0] crc;
    crc        = crc_init;
    wire_bytes = {};
    for (int i = 0; i < preamble_len; i++) begin
        wire_bytes.push_back(preamble_byte);
    end
    wire_bytes.push_back(sfd_byte);
    foreach (padded[i]) begin
        wire_bytes.push_back(padded[i]);
        crc = crc_byte(crc, padded[i]);
    end
    crc = ~crc;
    for (int i = 0; i < 4; i++) begin
        wire_bytes.push_back(crc[8*i +: 8]);
    end
endfunction

`default_nettype wire
`endif

//--- testbench/tb_ethernet_mac.sv
`default_nettype none

module tb_ethernet_mac
    import eth_pkg::*;
();

    timeunit 1ns;
    timeprecision 1ps;

    `include "eth_frame_model.svh"

    localparam int num_frames = 30;
    localparam int ifg_size   = 12;
    localparam int speed_wait = 300;    // clk_125 cycles per link speed step

    // Error injection per frame
    localparam int mode_none  = 0;
    localparam int mode_flip  = 1;      // One payload bit inverted on the loop
    localparam int mode_rx_er = 2;      // gmii_rx_er forced on one byte
    localparam int mode_stall = 3;      // Sink not ready for one byte

    logic       clk_125;
    logic       reset;
    logic       phy_rxc;
    logic [7:0] gmii_rx_d;
    logic       gmii_rx_dv;
    logic       gmii_rx_er;
    logic [7:0] gmii_tx_d;
    logic       gmii_tx_en;
    logic       gmii_tx_er;
    logic [7:0] s_tx_axis_tdata;
    logic       s_tx_axis_tvalid;
    logic       s_tx_axis_tlast;
    logic       s_tx_axis_trdy;
    logic [7:0] m_rx_axis_tdata;
    logic       m_rx_axis_tvalid;
    logic       m_rx_axis_tlast;
    logic       m_rx_axis_tuser;
    logic       s_rx_axis_trdy;
    logic [1:0] link_speed;

    realtime rxc_half = 4.0;            // phy_rxc half period in ns

    // Per-frame stimulus and expected streams
    int         tx_len   [num_frames];
    int         err_mode [num_frames];
    int         err_pos  [num_frames];  // Index into the padded payload
    logic [2:0] err_bit  [num_frames];
    byte_q_t    tx_data_q;              // Source bytes, all frames in order
    byte_q_t    tx_exp_q;               // Expected gmii_tx_d bytes
    byte_q_t    rx_exp_q;               // Expected m_rx_axis_tdata bytes
    logic       rx_exp_last_q [$];
    logic       rx_exp_user_q [$];

    int mismatch_cnt = 0;
    int failure_cnt  = 0;
    int cycle_cnt    = 0;
    int cycle_limit  = 0;

    // Monitor and loopback state
    int         tx_frame_idx = 0;
    int         tx_pos       = 0;
    int         tx_gap       = 0;
    logic       tx_en_prev   = 1'b0;
    logic       tx_in_payload;
    logic [7:0] tx_exp_d;
    int         rx_frame_cnt = 0;
    int         rx_pos       = 0;
    logic [7:0] rx_exp_d;
    logic       rx_exp_last;
    logic       rx_exp_user;
    int         lb_frame = 0;
    int         lb_pos   = 0;
    logic [7:0] lb_mask;
    logic       lb_er;

    ethernet_mac #(
        .IFG_SIZE            (ifg_size),
        .SPEED_100_THRESHOLD (16)
    ) i_ethernet_mac (
        .clk_125          (clk_125),
        .reset            (reset),
        .phy_rxc          (phy_rxc),
        .gmii_rx_d        (gmii_rx_d),
        .gmii_rx_dv       (gmii_rx_dv),
        .gmii_rx_er       (gmii_rx_er),
        .gmii_tx_d        (gmii_tx_d),
        .gmii_tx_en       (gmii_tx_en),
        .gmii_tx_er       (gmii_tx_er),
        .s_tx_axis_tdata  (s_tx_axis_tdata),
        .s_tx_axis_tvalid (s_tx_axis_tvalid),
        .s_tx_axis_tlast  (s_tx_axis_tlast),
        .s_tx_axis_trdy   (s_tx_axis_trdy),
        .m_rx_axis_tdata  (m_rx_axis_tdata),
        .m_rx_axis_tvalid (m_rx_axis_tvalid),
        .m_rx_axis_tlast  (m_rx_axis_tlast),
        .m_rx_axis_tuser  (m_rx_axis_tuser),
        .s_rx_axis_trdy   (s_rx_axis_trdy),
        .link_speed       (link_speed)
    );

    initial begin
        clk_125 = 1'b0;
        forever #5 clk_125 = ~clk_125;    // 10 ns period
    end

    initial begin
        phy_rxc = 1'b0;
        forever #(rxc_half) phy_rxc = ~phy_rxc;    // Rate follows rxc_half
    end

    task automatic report_mismatch(input string signal, input logic [31:0] expected,
                                   input logic [31:0] actual);
        mismatch_cnt++;
        $display("mismatch at %0.1f ns: %s expected %0h actual %0h",
                 $realtime, signal, expected, actual);
    endtask

    task automatic report_failure(input string what);
        failure_cnt++;
        $display("error at %0.1f ns: %s", $realtime, what);
    endtask

    task automatic print_counts();
        $display("summary: %0d mismatches, %0d other failures, %0d of %0d frames received",
                 mismatch_cnt, failure_cnt, rx_frame_cnt, num_frames);
    endtask

    // Random payloads, error choices and the expected streams on both sides
    task automatic generate_frames();
        byte_q_t    payload;
        byte_q_t    padded;
        byte_q_t    wire_bytes;
        logic [7:0] rx_byte;
        int         len;
        int         sum;
        sum = 0;
        for (int f = 0; f < num_frames; f++) begin
            len = int'(random_bits(7)) % 100 + 1;    // 1 to 100 bytes
            payload.delete();
            for (int i = 0; i < len; i++) begin
                payload.push_back(8'(random_bits(8)));
            end
            pad_payload(payload, padded);
            build_wire_frame(padded, wire_bytes);
            tx_len[f]   = len;
            err_mode[f] = (f % 5 == 4) ? (f / 5) % 3 + 1 : mode_none;
            err_pos[f]  = int'(random_bits(7)) % (padded.size() - 1);    // Never the last byte
            err_bit[f]  = 3'(random_bits(3));
            foreach (payload[i]) begin
                tx_data_q.push_back(payload[i]);
            end
            foreach (wire_bytes[i]) begin
                tx_exp_q.push_back(wire_bytes[i]);
            end
            foreach (padded[i]) begin
                rx_byte = padded[i];
                if (err_mode[f] == mode_flip && i == err_pos[f]) begin
                    rx_byte = rx_byte ^ (8'h01 << err_bit[f]);    // Flipped on the loop
                end
                rx_exp_q.push_back(rx_byte);
                rx_exp_last_q.push_back(i == padded.size() - 1);
                rx_exp_user_q.push_back((i == padded.size() - 1) && (err_mode[f] != mode_none));
            end
            sum += padded.size() + 8 + 4 + ifg_size;
        end
        cycle_limit = 2 * (sum + 3 * speed_wait);
    endtask

    // Holds tvalid high for the whole frame, next byte after each handshake
    task automatic send_frame(input int len);
        int   idx;
        logic taken;
        idx              = 0;
        s_tx_axis_tvalid = 1'b1;
        s_tx_axis_tdata  = tx_data_q.pop_front();
        s_tx_axis_tlast  = (len == 1);
        while (idx < len) begin
            taken = s_tx_axis_trdy;    // Stable until the coming edge
            @(posedge clk_125);
            #1;
            if (taken) begin
                idx++;
                if (idx < len) begin
                    s_tx_axis_tdata = tx_data_q.pop_front();
                    s_tx_axis_tlast = (idx == len - 1);
                end else begin
                    s_tx_axis_tvalid = 1'b0;
                    s_tx_axis_tlast  = 1'b0;
                    s_tx_axis_tdata  = 8'h00;
                end
            end
        end
    endtask

    task automatic check_link_speed(input realtime half_period, input logic [1:0] expected);
        rxc_half = half_period;
        repeat (speed_wait) @(posedge clk_125);
        #1;
        assert (link_speed == expected)
            else report_mismatch("link_speed", 32'(expected), 32'(link_speed));
    endtask

    // GMII loopback, one register stage, with error injection
    always @(posedge clk_125) begin
        #1;
        lb_mask = 8'h00;
        lb_er   = gmii_tx_er;
        if (gmii_tx_en && lb_frame < num_frames) begin
            if (lb_pos == 8 + err_pos[lb_frame]) begin    // Payload starts after SFD
                if (err_mode[lb_frame] == mode_flip) begin
                    lb_mask = 8'h01 << err_bit[lb_frame];
                end
                if (err_mode[lb_frame] == mode_rx_er) begin
                    lb_er = 1'b1;
                end
            end
            lb_pos++;
        end else if (!gmii_tx_en && lb_pos != 0) begin
            lb_frame++;    // Frame over
            lb_pos = 0;
        end
        gmii_rx_d  = gmii_tx_d ^ lb_mask;
        gmii_rx_dv = gmii_tx_en;
        gmii_rx_er = lb_er;
    end

    // Transmit checker: wire bytes, gap length and trdy window
    always @(posedge clk_125) begin
        #1;
        assert (!gmii_tx_er) else report_failure("gmii_tx_er raised on a complete frame");
        if (gmii_tx_en) begin
            if (tx_frame_idx >= num_frames) begin
                report_failure("transmit activity after the last frame");
            end else begin
                if (!tx_en_prev && tx_frame_idx > 0) begin
                    assert (tx_gap >= ifg_size)
                        else report_failure($sformatf("inter-frame gap of %0d cycles", tx_gap));
                end
                tx_in_payload = (tx_pos >= preamble_len) &&
                                (tx_pos < preamble_len + tx_len[tx_frame_idx]);
                assert (s_tx_axis_trdy == tx_in_payload)
                    else report_mismatch("s_tx_axis_trdy", 32'(tx_in_payload),
                                         32'(s_tx_axis_trdy));
                if (tx_exp_q.size() == 0) begin
                    report_failure("transmit frame longer than expected");
                end else begin
                    tx_exp_d = tx_exp_q.pop_front();
                    assert (gmii_tx_d == tx_exp_d)
                        else report_mismatch("gmii_tx_d", 32'(tx_exp_d), 32'(gmii_tx_d));
                end
            end
            tx_pos++;
            tx_gap = 0;
        end else begin
            assert (!s_tx_axis_trdy)
                else report_mismatch("s_tx_axis_trdy", 32'(0), 32'(s_tx_axis_trdy));
            if (tx_en_prev) begin
                tx_frame_idx++;
                tx_pos = 0;
            end
            tx_gap++;
        end
        tx_en_prev = gmii_tx_en;
    end

    // Receive checker and sink, trdy dropped for one byte on stall frames
    always @(posedge clk_125) begin
        #1;
        s_rx_axis_trdy = 1'b1;
        if (m_rx_axis_tvalid) begin
            if (rx_exp_q.size() == 0) begin
                report_failure("receive byte with no frame pending");
            end else begin
                rx_exp_d    = rx_exp_q.pop_front();
                rx_exp_last = rx_exp_last_q.pop_front();
                rx_exp_user = rx_exp_user_q.pop_front();
                assert (m_rx_axis_tdata == rx_exp_d)
                    else report_mismatch("m_rx_axis_tdata", 32'(rx_exp_d), 32'(m_rx_axis_tdata));
                assert (m_rx_axis_tlast == rx_exp_last)
                    else report_mismatch("m_rx_axis_tlast", 32'(rx_exp_last),
                                         32'(m_rx_axis_tlast));
                assert (m_rx_axis_tuser == rx_exp_user)
                    else report_mismatch("m_rx_axis_tuser", 32'(rx_exp_user),
                                         32'(m_rx_axis_tuser));
                if (err_mode[rx_frame_cnt] == mode_stall && rx_pos == err_pos[rx_frame_cnt]) begin
                    s_rx_axis_trdy = 1'b0;    // This byte is lost
                end
                rx_pos++;
                if (rx_exp_last) begin
                    rx_frame_cnt++;
                    rx_pos = 0;
                end
            end
        end
    end

    // Watchdog
    initial begin
        wait (cycle_limit != 0);
        while (cycle_cnt < cycle_limit) begin
            @(posedge clk_125);
            cycle_cnt++;
        end
        report_failure($sformatf("timeout, run not finished after %0d cycles", cycle_limit));
        print_counts();
        $display("*** FAILED ***");
        $finish;
    end

    initial begin
        reset            = 1'b1;
        s_tx_axis_tdata  = 8'h00;
        s_tx_axis_tvalid = 1'b0;
        s_tx_axis_tlast  = 1'b0;
        s_rx_axis_trdy   = 1'b1;
        gmii_rx_d        = 8'h00;
        gmii_rx_dv       = 1'b0;
        gmii_rx_er       = 1'b0;
        generate_frames();
        repeat (4) @(posedge clk_125);
        #1;
        reset = 1'b0;

        // Frames back to back, the loop feeds them into the receiver
        for (int f = 0; f < num_frames; f++) begin
            send_frame(tx_len[f]);
        end
        wait (rx_frame_cnt == num_frames);
        @(posedge clk_125);
        #1;

        check_link_speed(4.0, link_1000);     // 125 MHz
        check_link_speed(20.0, link_100);     // 25 MHz
        check_link_speed(200.0, link_10);     // 2.5 MHz

        assert (tx_exp_q.size() == 0) else report_failure("transmit bytes missing");
        assert (rx_exp_q.size() == 0) else report_failure("receive bytes missing");
        print_counts();
        if (mismatch_cnt + failure_cnt == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule : tb_ethernet_mac

`default_nettype wire

//--- ethernet_mac.f
+incdir+testbench
logic/eth_pkg.sv
logic/crc32_engine.sv
logic/tx_mac.sv
logic/rx_mac.sv
logic/link_speed_detect.sv
logic/ethernet_mac.sv
testbench/tb_ethernet_mac.sv
